// ==== common/spi_regs_config.svh ====
// Width and depth macros for the SPI register peek/poke subsystem
// Shared by the package and the register banks

`ifndef SPI_REGS_CONFIG_SVH
`define SPI_REGS_CONFIG_SVH

// Raw SPI byte address, top two bits pick the device
`define SPI_ADDR_BITS 32

// One configuration word
`define VAL_BITS 32

// Registers per device bank
`define BANK_WORDS 16

`endif

// ==== common/spi_regs_pkg.sv ====
// Types for the SPI register subsystem
// Address and data vectors, command codes, receiver states, request structs

`include "spi_regs_config.svh"

package spi_regs_pkg;

  typedef logic [`SPI_ADDR_BITS-1:0] spi_addr_t;
  // Device bits and byte bits stripped
  typedef logic [`SPI_ADDR_BITS-5:0] word_addr_t;
  typedef logic [`VAL_BITS-1:0] val_t;
  typedef logic [7:0] spi_cmd_t;

  localparam spi_cmd_t CMD_WRITE = 8'h02;
  localparam spi_cmd_t CMD_READ = 8'h03;

  typedef enum logic [2:0] {IDLE, CMD, ADDR, DATA, DONE} spi_state_e;

  // Receiver to decoder
  typedef struct packed {
    logic      read;
    logic      write;
    spi_addr_t addr;
    val_t      wdata;
  } reg_req_t;

  // Decoder to one bank
  typedef struct packed {
    logic       read;
    logic       write;
    word_addr_t addr;
    val_t       wdata;
  } dev_req_t;

endpackage

// ==== spi_slave/spi_slave.sv ====
// Mode-0 SPI frame receiver with pin synchronizers
// Turns command/address/data frames into read and write strobes, shifts read data out

`timescale 1ns/10ps

module spi_slave import spi_regs_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     sclk,
  input  logic     mosi,
  input  logic     ss_n,
  output logic     miso,
  output reg_req_t req,
  input  val_t     rdata
);

  localparam int WORD_MSB = $bits(val_t) - 1;
  localparam int ADDR_MSB = $bits(spi_addr_t) - 1;

  // Two flops per pin, plus last sclk for edge detection
  logic [1:0] sclk_sync;
  logic [1:0] mosi_sync;
  logic [1:0] ss_sync;
  logic       sclk_prev;

  logic sclk_rise;
  logic sclk_fall;
  logic ss_active;
  logic mosi_bit;

  spi_state_e state;
  logic [4:0] bit_cnt;
  logic       last_bit;

  spi_cmd_t  cmd_sr;
  spi_cmd_t  cmd_next;
  spi_addr_t addr_sr;
  val_t      data_sr;
  val_t      tx_sr;

  logic       read_q;
  logic       write_q;
  // Read strobe delayed until the bank holding word is settled
  logic [1:0] load_dly;

  always_ff @(posedge clk) begin
    if (reset) begin
      sclk_sync <= '0;
      mosi_sync <= '0;
      ss_sync   <= 2'b11;
      sclk_prev <= 1'b0;
    end else begin
      sclk_sync <= {sclk_sync[0], sclk};
      mosi_sync <= {mosi_sync[0], mosi};
      ss_sync   <= {ss_sync[0], ss_n};
      sclk_prev <= sclk_sync[1];
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_prev;
  assign sclk_fall = ~sclk_sync[1] & sclk_prev;
  assign ss_active = ~ss_sync[1];
  assign mosi_bit  = mosi_sync[1];

  assign cmd_next = {cmd_sr[6:0], mosi_bit};

  // Final bit of the current field
  always_comb begin
    case (state)
      CMD:        last_bit = (bit_cnt == 5'd7);
      ADDR, DATA: last_bit = (bit_cnt == 5'd31);
      default:    last_bit = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      bit_cnt <= '0;
      cmd_sr  <= '0;
      read_q  <= 1'b0;
      write_q <= 1'b0;
    end else begin
      read_q  <= 1'b0;
      write_q <= 1'b0;
      if (!ss_active) begin
        // Frame ended or cut short
        state   <= IDLE;
        bit_cnt <= '0;
      end else begin
        case (state)
          IDLE: begin
            state   <= CMD;
            bit_cnt <= '0;
          end
          CMD: begin
            if (sclk_rise) begin
              cmd_sr  <= cmd_next;
              bit_cnt <= bit_cnt + 5'd1;
              if (last_bit) begin
                bit_cnt <= '0;
                // Unknown commands skip straight to the end of frame
                if (cmd_next == CMD_READ || cmd_next == CMD_WRITE) begin
                  state <= ADDR;
                end else begin
                  state <= DONE;
                end
              end
            end
          end
          ADDR: begin
            if (sclk_rise) begin
              bit_cnt <= bit_cnt + 5'd1;
              if (last_bit) begin
                bit_cnt <= '0;
                state   <= DATA;
                read_q  <= (cmd_sr == CMD_READ);
              end
            end
          end
          DATA: begin
            if (sclk_rise) begin
              bit_cnt <= bit_cnt + 5'd1;
              if (last_bit) begin
                state   <= DONE;
                write_q <= (cmd_sr == CMD_WRITE);
              end
            end
          end
          default: begin
            state <= DONE;
          end
        endcase
      end
    end
  end

  // Address and write data shifters, MSB first
  always_ff @(posedge clk) begin
    if (sclk_rise && state == ADDR) begin
      addr_sr <= {addr_sr[ADDR_MSB-1:0], mosi_bit};
    end
    if (sclk_rise && state == DATA) begin
      data_sr <= {data_sr[WORD_MSB-1:0], mosi_bit};
    end
  end

  // Read data out, first bit held over the fall that follows the address
  always_ff @(posedge clk) begin
    if (reset) begin
      load_dly <= '0;
      tx_sr    <= '0;
    end else begin
      load_dly <= {load_dly[0], read_q};
      if (!ss_active) begin
        tx_sr <= '0;
      end else if (load_dly[1]) begin
        tx_sr <= rdata;
      end else if (sclk_fall && state == DATA && bit_cnt != '0) begin
        tx_sr <= {tx_sr[WORD_MSB-1:0], 1'b0};
      end
    end
  end

  assign miso = tx_sr[WORD_MSB];

  assign req = '{read: read_q, write: write_q, addr: addr_sr, wdata: data_sr};

endmodule

// ==== hdl/spi_address_decode.sv ====
// Device decoder for SPI peek/poke requests
// Routes strobes by the top two address bits and muxes the read word back

`timescale 1ns/10ps

`include "spi_regs_config.svh"

module spi_address_decode import spi_regs_pkg::*; (
  input  reg_req_t       req,
  output val_t           rdata,
  output dev_req_t [1:0] b2b_req,
  output dev_req_t       periph_req,
  output dev_req_t       ring_req,
  input  val_t     [1:0] b2b_rdata,
  input  val_t           periph_rdata,
  input  val_t           ring_rdata
);

  // Device codes in the top two address bits
  localparam logic [1:0] B2B0_SEL   = 2'b00;
  localparam logic [1:0] B2B1_SEL   = 2'b01;
  localparam logic [1:0] PERIPH_SEL = 2'b10;
  localparam logic [1:0] RING_SEL   = 2'b11;

  logic [1:0] dev_sel;
  word_addr_t word_addr;

  assign dev_sel   = req.addr[`SPI_ADDR_BITS-1 -: 2];
  // Drop device bits and byte offset
  assign word_addr = req.addr[`SPI_ADDR_BITS-3:2];

  // Request seen by one device, strobes only when selected
  function automatic dev_req_t route(input reg_req_t r, input word_addr_t a,
                                     input logic hit);
    dev_req_t d;
    d.read  = r.read && hit;
    d.write = r.write && hit;
    d.addr  = a;
    d.wdata = r.wdata;
    return d;
  endfunction

  assign b2b_req[0] = route(req, word_addr, dev_sel == B2B0_SEL);
  assign b2b_req[1] = route(req, word_addr, dev_sel == B2B1_SEL);
  assign periph_req = route(req, word_addr, dev_sel == PERIPH_SEL);
  assign ring_req   = route(req, word_addr, dev_sel == RING_SEL);

  // Read value mux
  always_comb begin
    case (dev_sel)
      B2B0_SEL:   rdata = b2b_rdata[0];
      B2B1_SEL:   rdata = b2b_rdata[1];
      PERIPH_SEL: rdata = periph_rdata;
      default:    rdata = ring_rdata;
    endcase
  end

endmodule

// ==== hdl/hss_reg_bank.sv ====
// Configuration register bank for one high-speed serial device
// Write port plus a read holding word that keeps the last value read

`timescale 1ns/10ps

`include "spi_regs_config.svh"

module hss_reg_bank import spi_regs_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  dev_req_t req,
  output val_t     rdata
);

  localparam int IDX_BITS = $clog2(`BANK_WORDS);

  val_t                regs [`BANK_WORDS];
  logic [IDX_BITS-1:0] idx;

  // Upper word address bits ignored, so addresses alias
  assign idx = req.addr[IDX_BITS-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `BANK_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (req.write) begin
      regs[idx] <= req.wdata;
    end
  end

  // Holding word, stable until the next read strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      rdata <= '0;
    end else if (req.read) begin
      rdata <= regs[idx];
    end
  end

endmodule

// ==== hdl/spi_regs_top.sv ====
// Top level of the SPI register subsystem
// SPI receiver, device decoder and the four device register banks

`timescale 1ns/10ps

module spi_regs_top import spi_regs_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic sclk,
  input  logic mosi,
  input  logic ss_n,
  output logic miso
);

  reg_req_t       req;
  val_t           rdata;
  dev_req_t [1:0] b2b_req;
  dev_req_t       periph_req;
  dev_req_t       ring_req;
  val_t     [1:0] b2b_rdata;
  val_t           periph_rdata;
  val_t           ring_rdata;

  spi_slave i_spi_slave (
    .clk   (clk),
    .reset (reset),
    .sclk  (sclk),
    .mosi  (mosi),
    .ss_n  (ss_n),
    .miso  (miso),
    .req   (req),
    .rdata (rdata)
  );

  spi_address_decode i_decode (
    .req          (req),
    .rdata        (rdata),
    .b2b_req      (b2b_req),
    .periph_req   (periph_req),
    .ring_req     (ring_req),
    .b2b_rdata    (b2b_rdata),
    .periph_rdata (periph_rdata),
    .ring_rdata   (ring_rdata)
  );

  // Board-to-board links
  hss_reg_bank i_b2b0 (
    .clk   (clk),
    .reset (reset),
    .req   (b2b_req[0]),
    .rdata (b2b_rdata[0])
  );

  hss_reg_bank i_b2b1 (
    .clk   (clk),
    .reset (reset),
    .req   (b2b_req[1]),
    .rdata (b2b_rdata[1])
  );

  hss_reg_bank i_periph (
    .clk   (clk),
    .reset (reset),
    .req   (periph_req),
    .rdata (periph_rdata)
  );

  hss_reg_bank i_ring (
    .clk   (clk),
    .reset (reset),
    .req   (ring_req),
    .rdata (ring_rdata)
  );

endmodule

// ==== tb/spi_regs_tb.sv ====
// Testbench for the SPI register subsystem
// Bit-banged SPI frames from a stimulus table and a reference model of all four banks

`timescale 1ns/10ps

module spi_regs_tb import spi_regs_pkg::*; ();

  localparam int HALF_CLKS = 8;
  localparam int FRAME_BITS = 72;
  localparam int RESET_CLKS = 16;
  localparam logic [31:0] SEED = 32'h9b65;
  localparam spi_cmd_t CMD_BAD = 8'h0B;

  // Stimulus and expected read for one frame
  typedef struct packed {
    spi_cmd_t  cmd;
    spi_addr_t addr;
    val_t      wdata;
    val_t      exp_rd;
    int        nbits;
  } entry_t;

  logic clk;
  logic reset;
  logic sclk;
  logic mosi;
  logic ss_n;
  logic miso;

  entry_t tests_q[$];
  string  names_q[$];
  val_t   model [4][16];

  int pass_cnt;
  int fail_cnt;
  int cycle_cnt;
  int cycle_limit;

  spi_regs_top i_dut (
    .clk   (clk),
    .reset (reset),
    .sclk  (sclk),
    .mosi  (mosi),
    .ss_n  (ss_n),
    .miso  (miso)
  );

  always #5 clk = ~clk;

  // Cycle counter that ends a stuck run
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  // Byte address from device code, word address and byte offset
  function automatic spi_addr_t make_addr(input logic [1:0] dev, input logic [27:0] word,
                                          input logic [1:0] byte_off);
    return {dev, word, byte_off};
  endfunction

  task automatic wait_clk(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Adds one entry and keeps the model in step with complete writes
  task automatic add_test(input string name, input spi_cmd_t cmd, input spi_addr_t addr,
                          input int nbits);
    entry_t     e;
    logic [1:0] dev;
    logic [3:0] idx;
    dev      = addr[31:30];
    idx      = addr[5:2];
    e.cmd    = cmd;
    e.addr   = addr;
    e.wdata  = $urandom;
    e.nbits  = nbits;
    e.exp_rd = '0;
    if (cmd == CMD_WRITE && nbits == FRAME_BITS) begin
      model[dev][idx] = e.wdata;
    end
    if (cmd == CMD_READ && nbits == FRAME_BITS) begin
      e.exp_rd = model[dev][idx];
    end
    tests_q.push_back(e);
    names_q.push_back(name);
  endtask

  // Mode-0 frame with MISO sampled while SCLK is low before each rise
  task automatic run_frame(input entry_t e, output val_t rd);
    logic [71:0] bits;
    bits = {e.cmd, e.addr, e.wdata};
    rd   = '0;
    ss_n = 1'b0;
    for (int i = 0; i < e.nbits; i++) begin
      mosi = bits[71-i];
      wait_clk(HALF_CLKS);
      if (i >= 40) begin
        rd = {rd[30:0], miso};
      end
      sclk = 1'b1;
      wait_clk(HALF_CLKS);
      sclk = 1'b0;
    end
    wait_clk(HALF_CLKS);
    ss_n = 1'b1;
    mosi = 1'b0;
    wait_clk(2 * HALF_CLKS);
  endtask

  task automatic build_table();
    // Reset values
    add_test("reset_b2b0_idx0", CMD_READ, make_addr(2'd0, 28'h0, 2'd0), FRAME_BITS);
    add_test("reset_b2b0_idx12", CMD_READ, make_addr(2'd0, 28'hC, 2'd0), FRAME_BITS);
    add_test("reset_b2b1_idx5", CMD_READ, make_addr(2'd1, 28'h5, 2'd0), FRAME_BITS);
    add_test("reset_b2b1_idx0", CMD_READ, make_addr(2'd1, 28'h0, 2'd0), FRAME_BITS);
    add_test("reset_periph_idx15", CMD_READ, make_addr(2'd2, 28'hF, 2'd0), FRAME_BITS);
    add_test("reset_periph_idx3", CMD_READ, make_addr(2'd2, 28'h3, 2'd0), FRAME_BITS);
    add_test("reset_ring_idx9", CMD_READ, make_addr(2'd3, 28'h9, 2'd0), FRAME_BITS);
    add_test("reset_ring_idx14", CMD_READ, make_addr(2'd3, 28'hE, 2'd0), FRAME_BITS);
    // Write then read back in each device
    add_test("wr_b2b0_idx3", CMD_WRITE, make_addr(2'd0, 28'h3, 2'd0), FRAME_BITS);
    add_test("rd_b2b0_idx3", CMD_READ, make_addr(2'd0, 28'h3, 2'd0), FRAME_BITS);
    add_test("wr_b2b1_idx7", CMD_WRITE, make_addr(2'd1, 28'h7, 2'd0), FRAME_BITS);
    add_test("rd_b2b1_idx7", CMD_READ, make_addr(2'd1, 28'h7, 2'd0), FRAME_BITS);
    add_test("wr_periph_idx12", CMD_WRITE, make_addr(2'd2, 28'hC, 2'd0), FRAME_BITS);
    add_test("rd_periph_idx12", CMD_READ, make_addr(2'd2, 28'hC, 2'd0), FRAME_BITS);
    add_test("wr_ring_idx1", CMD_WRITE, make_addr(2'd3, 28'h1, 2'd0), FRAME_BITS);
    add_test("rd_ring_idx1", CMD_READ, make_addr(2'd3, 28'h1, 2'd0), FRAME_BITS);
    // Same index in every device
    add_test("wr_b2b0_idx10", CMD_WRITE, make_addr(2'd0, 28'hA, 2'd0), FRAME_BITS);
    add_test("wr_b2b1_idx10", CMD_WRITE, make_addr(2'd1, 28'hA, 2'd0), FRAME_BITS);
    add_test("wr_periph_idx10", CMD_WRITE, make_addr(2'd2, 28'hA, 2'd0), FRAME_BITS);
    add_test("wr_ring_idx10", CMD_WRITE, make_addr(2'd3, 28'hA, 2'd0), FRAME_BITS);
    add_test("rd_b2b0_idx10", CMD_READ, make_addr(2'd0, 28'hA, 2'd0), FRAME_BITS);
    add_test("rd_b2b1_idx10", CMD_READ, make_addr(2'd1, 28'hA, 2'd0), FRAME_BITS);
    add_test("rd_periph_idx10", CMD_READ, make_addr(2'd2, 28'hA, 2'd0), FRAME_BITS);
    add_test("rd_ring_idx10", CMD_READ, make_addr(2'd3, 28'hA, 2'd0), FRAME_BITS);
    // Aliasing through upper word bits and byte bits
    add_test("wr_periph_alias_hi", CMD_WRITE, make_addr(2'd2, 28'h35, 2'd0), FRAME_BITS);
    add_test("rd_periph_idx5", CMD_READ, make_addr(2'd2, 28'h5, 2'd0), FRAME_BITS);
    add_test("rd_ring_alias_hi", CMD_READ, make_addr(2'd3, 28'hABCDE1, 2'd0), FRAME_BITS);
    add_test("wr_b2b1_byte3", CMD_WRITE, make_addr(2'd1, 28'h2, 2'd3), FRAME_BITS);
    add_test("rd_b2b1_byte0", CMD_READ, make_addr(2'd1, 28'h2, 2'd0), FRAME_BITS);
    add_test("rd_b2b0_alias_mix", CMD_READ, make_addr(2'd0, 28'hFFFFFF3, 2'd2), FRAME_BITS);
    // Dropped frames leave the banks alone
    add_test("bad_cmd_b2b0_idx3", CMD_BAD, make_addr(2'd0, 28'h3, 2'd0), FRAME_BITS);
    add_test("rd_b2b0_after_bad", CMD_READ, make_addr(2'd0, 28'h3, 2'd0), FRAME_BITS);
    add_test("cut60_wr_b2b1_idx7", CMD_WRITE, make_addr(2'd1, 28'h7, 2'd0), 60);
    add_test("rd_b2b1_after_cut60", CMD_READ, make_addr(2'd1, 28'h7, 2'd0), FRAME_BITS);
    add_test("cut71_wr_ring_idx10", CMD_WRITE, make_addr(2'd3, 28'hA, 2'd0), 71);
    add_test("rd_ring_after_cut71", CMD_READ, make_addr(2'd3, 28'hA, 2'd0), FRAME_BITS);
  endtask

  initial begin
    val_t   rd;
    entry_t e;
    clk       = 1'b0;
    reset     = 1'b1;
    sclk      = 1'b0;
    mosi      = 1'b0;
    ss_n      = 1'b1;
    pass_cnt  = 0;
    fail_cnt  = 0;
    cycle_cnt = 0;
    void'($urandom(SEED));
    for (int d = 0; d < 4; d++) begin
      for (int w = 0; w < 16; w++) begin
        model[d][w] = '0;
      end
    end
    build_table();
    // Each bit takes two half periods plus frame gaps and reset
    cycle_limit = tests_q.size() * FRAME_BITS * 2 * HALF_CLKS + tests_q.size() * 64 + 200;

    wait_clk(RESET_CLKS);
    reset = 1'b0;
    wait_clk(4);

    for (int t = 0; t < tests_q.size(); t++) begin
      e = tests_q[t];
      run_frame(e, rd);
      if (rd !== e.exp_rd) begin
        $display("[FAIL] %s expected %h actual %h", names_q[t], e.exp_rd, rd);
        fail_cnt = fail_cnt + 1;
      end else begin
        $display("[PASS] %s read %h", names_q[t], rd);
        pass_cnt = pass_cnt + 1;
      end
    end

    $display("Tests run %0d, passed %0d, failed %0d", tests_q.size(), pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+common
common/spi_regs_pkg.sv
spi_slave/spi_slave.sv
hdl/spi_address_decode.sv
hdl/hss_reg_bank.sv
hdl/spi_regs_top.sv
tb/spi_regs_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the SPI register testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f all.f --top-module spi_regs_tb -o spi_regs_sim \
  && ./obj_dir/spi_regs_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log \
  && { echo "Result: FAIL"; exit 1; } \
  || { echo "Result: PASS"; exit 0; }
